//--- include/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data word width.
`define LSU_DW 32

// ram word-address bits, 64 words.
`define LSU_RAM_AW 6

// serial counter, one step per data bit.
`define LSU_CNT_W 5

`endif

//--- rtl/lsu_pkg.sv
package lsu_pkg;

   // riscv funct3 width codes for loads and stores.
   typedef enum logic [2:0] {
      LSU_B  = 3'd0,
      LSU_H  = 3'd1,
      LSU_W  = 3'd2,
      LSU_BU = 3'd4,
      LSU_HU = 3'd5
   } lsu_width_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_INIT,  // store data shifts into the byte lanes.
      ST_CHECK, // misalign flag is sampled.
      ST_BUS,   // single word access.
      ST_SHIFT, // load result shifts out.
      ST_DONE
   } seq_state_t;

endpackage

//--- rtl/lsu_bus_if.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

interface lsu_bus_if;

   logic [`LSU_RAM_AW-1:0] adr;
   logic                   stb;
   logic                   we;
   logic [`LSU_DW-1:0]     dat;
   logic [`LSU_DW/8-1:0]   sel;
   logic [`LSU_DW-1:0]     rdt;
   logic                   ack;

   modport ctrl (output adr, output stb, input ack);

   modport data (output we, output dat, output sel, input rdt, input ack);

   modport mem (
      input  adr, stb, we, dat, sel,
      output rdt, ack
   );

endinterface

//--- rtl/lsu_sequencer.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_sequencer (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_start,
   input  logic                i_store,
   input  lsu_pkg::lsu_width_t i_funct3,
   input  logic [31:0]         i_addr,
   input  logic [`LSU_DW-1:0]  i_wdata,
   input  logic                i_rd,
   input  logic                i_misalign,
   output logic                o_en,
   output logic                o_init,
   output logic [1:0]          o_bytecnt,
   output logic                o_rs2,
   output logic [1:0]          o_lsb,
   output logic                o_cmd,
   output lsu_pkg::lsu_width_t o_funct3,
   output logic                o_busy,
   output logic                o_done,
   output logic [`LSU_DW-1:0]  o_rdata,
   output logic                o_err_misalign,
   lsu_bus_if.ctrl             bus
);
   import lsu_pkg::*;

   seq_state_t            state;
   logic [`LSU_CNT_W-1:0] cnt;
   logic                  cnt_last;
   logic                  start_ok;
   logic                  store_r;
   lsu_width_t            funct3_r;
   logic [31:0]           addr_r;
   logic [`LSU_DW-1:0]    shreg;

   assign cnt_last = &cnt;
   assign start_ok = i_start & (state == ST_IDLE); // starts while busy are dropped.

   // ==================================================
   // state machine and serial counter
   // ==================================================
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state          <= ST_IDLE;
         cnt            <= '0;
         o_err_misalign <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (start_ok)
                  state <= ST_INIT;
            end
            ST_INIT: begin
               if (cnt_last)
                  state <= ST_CHECK;
            end
            ST_CHECK: state <= i_misalign ? ST_DONE : ST_BUS; // no access when misaligned.
            ST_BUS: begin
               if (bus.ack)
                  state <= store_r ? ST_DONE : ST_SHIFT;
            end
            ST_SHIFT: begin
               if (cnt_last)
                  state <= ST_DONE;
            end
            ST_DONE: state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase

         if (o_en)
            cnt <= cnt + 1'b1; // wraps to zero after each 32-bit pass.

         if (start_ok)
            o_err_misalign <= 1'b0;
         else if (state == ST_CHECK)
            o_err_misalign <= i_misalign;
      end
   end

   // ==================================================
   // command register and shift register
   // ==================================================
   // one register carries the store word out and the load word in.
   always_ff @(posedge i_clk) begin
      if (start_ok) begin
         store_r  <= i_store;
         funct3_r <= i_funct3;
         addr_r   <= i_addr;
         shreg    <= i_wdata;
      end else if (o_init) begin
         shreg <= {1'b0, shreg[`LSU_DW-1:1]}; // lsb first to the buffer.
      end else if (o_en) begin
         shreg <= {i_rd, shreg[`LSU_DW-1:1]}; // bit n lands in bit n after 32 steps.
      end
   end

   assign o_en      = (state == ST_INIT) | (state == ST_SHIFT);
   assign o_init    = (state == ST_INIT);
   assign o_bytecnt = cnt[`LSU_CNT_W-1 -: 2];
   assign o_rs2     = shreg[0];
   assign o_lsb     = addr_r[1:0];
   assign o_cmd     = store_r;
   assign o_funct3  = funct3_r;
   assign o_busy    = (state != ST_IDLE);
   assign o_done    = (state == ST_DONE);
   assign o_rdata   = shreg;

   assign bus.adr = addr_r[`LSU_RAM_AW+1:2]; // upper address bits are ignored.
   assign bus.stb = (state == ST_BUS);

endmodule

//--- rtl/ser_mem_if.sv
`timescale 1ns/1ps

module ser_mem_if (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_en,
   input  logic                i_init,
   input  logic [1:0]          i_bytecnt,
   input  logic                i_cmd,
   input  lsu_pkg::lsu_width_t i_funct3,
   input  logic                i_rs2,
   input  logic [1:0]          i_lsb,
   output logic                o_rd,
   output logic                o_misalign,
   lsu_bus_if.data             bus
);
   import lsu_pkg::*;

   logic [7:0] lane [0:3];
   logic [3:0] lane_en;
   logic [3:0] init_en;
   logic [3:0] wbyte;
   logic [1:0] bytepos;
   logic [1:0] dat_sel;
   logic       dat_cur;
   logic       dat_valid;
   logic       signbit;
   logic       is_word;
   logic       is_half;
   logic       is_byte;
   logic       is_signed;

   assign is_word   = (i_funct3 == LSU_W);
   assign is_half   = (i_funct3 == LSU_H) | (i_funct3 == LSU_HU);
   assign is_byte   = (i_funct3 == LSU_B) | (i_funct3 == LSU_BU);
   assign is_signed = (i_funct3 == LSU_B) | (i_funct3 == LSU_H);

   // ==================================================
   // load path
   // ==================================================
   assign dat_sel   = i_bytecnt[1] ? i_bytecnt : (i_bytecnt | bytepos);
   assign dat_cur   = lane[dat_sel][0];
   assign dat_valid = is_word | (i_bytecnt == 2'b00) | (is_half & ~i_bytecnt[1]);
   assign o_rd      = dat_valid ? dat_cur : (signbit & is_signed); // sign or zero fill.

   // ==================================================
   // store path
   // ==================================================
   // byte 0 goes to every lane, byte 1 to lanes 1 and 3 for aligned halves.
   assign wbyte[0] = (i_bytecnt == 2'd0);
   assign wbyte[1] = (i_bytecnt == 2'd1) & ~bytepos[0];
   assign wbyte[2] = (i_bytecnt == 2'd2) & ~bytepos[1];
   assign wbyte[3] = (i_bytecnt == 2'd3) & ~bytepos[1];

   assign init_en[0] = wbyte[0];
   assign init_en[1] = wbyte[0] | wbyte[1];
   assign init_en[2] = wbyte[0] | wbyte[2];
   assign init_en[3] = wbyte[0] | wbyte[1] | wbyte[3];

   always_comb begin
      for (int i = 0; i < 4; i++) begin
         lane_en[i] = i_en & (i_init ? init_en[i] : (dat_sel == i[1:0]));
      end
   end

   always_comb begin
      if (is_word)
         bus.sel = 4'b1111;
      else if (is_half)
         bus.sel = bytepos[1] ? 4'b1100 : 4'b0011;
      else
         bus.sel = 4'b0001 << bytepos;
   end

   assign bus.we  = i_cmd;
   assign bus.dat = {lane[3], lane[2], lane[1], lane[0]};

   always_ff @(posedge i_clk) begin
      for (int i = 0; i < 4; i++) begin
         if (bus.ack & ~bus.we)
            lane[i] <= bus.rdt[8*i +: 8]; // read word lands in all lanes.
         else if (lane_en[i])
            lane[i] <= {i_rs2, lane[i][7:1]};
      end
      if (i_init)
         bytepos <= i_lsb;
      if (dat_valid)
         signbit <= dat_cur; // last valid bit is the sign.
   end

   always_ff @(posedge i_clk) begin
      if (i_rst)
         o_misalign <= 1'b0;
      else
         o_misalign <= (bytepos[0] & ~is_byte) | (bytepos[1] & is_word);
   end

endmodule

//--- rtl/wb_ram.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module wb_ram (
   input  logic   i_clk,
   input  logic   i_rst,
   lsu_bus_if.mem bus
);

   localparam int DEPTH = 1 << `LSU_RAM_AW;

   logic [`LSU_DW-1:0] mem [0:DEPTH-1] = '{default: '0};
   logic               req;

   assign req = bus.stb & ~bus.ack; // a held strobe is served once.

   always_ff @(posedge i_clk) begin
      if (i_rst)
         bus.ack <= 1'b0;
      else
         bus.ack <= req;
   end

   always_ff @(posedge i_clk) begin
      if (req) begin
         if (bus.we) begin
            for (int b = 0; b < `LSU_DW/8; b++) begin
               if (bus.sel[b])
                  mem[bus.adr][8*b +: 8] <= bus.dat[8*b +: 8];
            end
         end
         bus.rdt <= mem[bus.adr];
      end
   end

endmodule

//--- rtl/ser_lsu_top.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module ser_lsu_top (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_start,
   input  logic                i_store,
   input  lsu_pkg::lsu_width_t i_funct3,
   input  logic [31:0]         i_addr,
   input  logic [`LSU_DW-1:0]  i_wdata,
   output logic                o_busy,
   output logic                o_done,
   output logic [`LSU_DW-1:0]  o_rdata,
   output logic                o_misalign
);
   import lsu_pkg::*;

   logic       en;
   logic       init;
   logic [1:0] bytecnt;
   logic       rs2;
   logic [1:0] lsb;
   logic       cmd;
   lsu_width_t funct3;
   logic       rd;
   logic       misalign;

   lsu_bus_if bus ();

   lsu_sequencer u_seq (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_start        (i_start),
      .i_store        (i_store),
      .i_funct3       (i_funct3),
      .i_addr         (i_addr),
      .i_wdata        (i_wdata),
      .i_rd           (rd),
      .i_misalign     (misalign),
      .o_en           (en),
      .o_init         (init),
      .o_bytecnt      (bytecnt),
      .o_rs2          (rs2),
      .o_lsb          (lsb),
      .o_cmd          (cmd),
      .o_funct3       (funct3),
      .o_busy         (o_busy),
      .o_done         (o_done),
      .o_rdata        (o_rdata),
      .o_err_misalign (o_misalign),
      .bus            (bus.ctrl)
   );

   ser_mem_if u_buf (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_en       (en),
      .i_init     (init),
      .i_bytecnt  (bytecnt),
      .i_cmd      (cmd),
      .i_funct3   (funct3),
      .i_rs2      (rs2),
      .i_lsb      (lsb),
      .o_rd       (rd),
      .o_misalign (misalign),
      .bus        (bus.data)
   );

   wb_ram u_ram (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .bus   (bus.mem)
   );

endmodule

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD_NS = 8
) (
   output logic o_clk
);

   initial o_clk = 1'b0;

   always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

//--- verif/ser_lsu_asserts.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module ser_lsu_asserts (
   input logic                i_clk,
   input logic                i_rst,
   input lsu_pkg::seq_state_t i_state,
   input logic                i_stb,
   input logic                i_ack,
   input logic                i_done
);
   import lsu_pkg::*;

   int                    fail_count = 0;
   logic [`LSU_CNT_W-1:0] init_len;

   always_ff @(posedge i_clk) begin
      if (i_rst || (i_state != ST_INIT))
         init_len <= '0;
      else
         init_len <= init_len + 1'b1; // cycles already spent in init.
   end

   // ==================================================
   // word bus handshake
   // ==================================================
   a_stb_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_stb && !i_ack |=> i_stb)
   else begin
      fail_count++;
      $error("stb dropped before ack");
   end

   a_stb_release: assert property (@(posedge i_clk) disable iff (i_rst)
      i_stb && i_ack |=> !i_stb)
   else begin
      fail_count++;
      $error("stb still high after ack");
   end

   a_ack_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ack |=> !i_ack)
   else begin
      fail_count++;
      $error("ack longer than one cycle");
   end

   a_ack_follows: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ack |-> $past(i_stb))
   else begin
      fail_count++;
      $error("ack without a request");
   end

   // ==================================================
   // sequencer timing
   // ==================================================
   a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
      i_done |=> !i_done)
   else begin
      fail_count++;
      $error("done longer than one cycle");
   end

   a_init_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_state == ST_INIT) && (init_len != '1) |=> (i_state == ST_INIT))
   else begin
      fail_count++;
      $error("init phase ended early");
   end

   a_init_exit: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_state == ST_INIT) && (init_len == '1) |=> (i_state == ST_CHECK))
   else begin
      fail_count++;
      $error("init phase longer than one word");
   end

endmodule

bind lsu_sequencer ser_lsu_asserts asserts0 (
   .i_clk   (i_clk),
   .i_rst   (i_rst),
   .i_state (state),
   .i_stb   (bus.stb),
   .i_ack   (bus.ack),
   .i_done  (o_done)
);

//--- verif/tb_ser_lsu.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module tb_ser_lsu;
   import lsu_pkg::*;

   localparam int CLK_NS     = 8;
   localparam int RST_CYCLES = 8;
   localparam int N_WORD     = 8;
   localparam int N_BYTE     = 4;
   localparam int N_SIGN     = 8;
   localparam int N_MIS      = 8;
   localparam int N_RAND     = 200;
   localparam int N_CMDS     = 2*N_WORD + 8*N_BYTE + 5*N_SIGN + 2*N_MIS + 4 + N_RAND;
   localparam int WDOG_NS    = (N_CMDS * 100 + RST_CYCLES) * CLK_NS;

   logic               clk;
   logic               rst;
   logic               start;
   logic               store;
   lsu_width_t         funct3;
   logic [31:0]        addr;
   logic [`LSU_DW-1:0] wdata;
   logic               busy;
   logic               done;
   logic [`LSU_DW-1:0] rdata;
   logic               misalign;

   logic [`LSU_DW-1:0] ref_mem [0:(1 << `LSU_RAM_AW)-1];
   logic [15:0]        lfsr_state = 16'd22748;
   int                 errors = 0;
   int                 checks = 0;
   int                 tests_run = 0;
   int                 tests_failed = 0;
   int                 err_mark = 0;

   tb_clkgen #(.PERIOD_NS(CLK_NS)) clkgen0 (.o_clk(clk));

   ser_lsu_top dut0 (
      .i_clk      (clk),
      .i_rst      (rst),
      .i_start    (start),
      .i_store    (store),
      .i_funct3   (funct3),
      .i_addr     (addr),
      .i_wdata    (wdata),
      .o_busy     (busy),
      .o_done     (done),
      .o_rdata    (rdata),
      .o_misalign (misalign)
   );

   // ==================================================
   // random source and reference rules
   // ==================================================
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // x^16+x^14+x^13+x^11+1.
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   function automatic lsu_width_t pick_width(input logic for_store);
      logic [2:0] r;
      do
         r = 3'(rand_bits(3));
      while ((r == 3'd3) || (r > 3'd5) || (for_store && (r > 3'd2))); // stores use b, h, w.
      return lsu_width_t'(r);
   endfunction

   function automatic logic is_misaligned(input lsu_width_t f3, input logic [31:0] a);
      case (f3)
         LSU_H, LSU_HU: return a[0];
         LSU_W:         return a[1:0] != 2'b00;
         default:       return 1'b0;
      endcase
   endfunction

   function automatic logic [31:0] load_value(input logic [31:0] word, input lsu_width_t f3,
                                              input logic [1:0] off);
      logic [7:0]  b;
      logic [15:0] h;
      b = word[8*off +: 8];
      h = off[1] ? word[31:16] : word[15:0];
      case (f3)
         LSU_B:   return {{24{b[7]}}, b};
         LSU_BU:  return {24'd0, b};
         LSU_H:   return {{16{h[15]}}, h};
         LSU_HU:  return {16'd0, h};
         default: return word;
      endcase
   endfunction

   function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [31:0] d,
                                               input lsu_width_t f3, input logic [1:0] off);
      logic [31:0] res;
      res = old;
      if (f3 == LSU_B)
         res[8*off +: 8] = d[7:0];
      else if ((f3 == LSU_H) && off[1])
         res[31:16] = d[15:0];
      else if (f3 == LSU_H)
         res[15:0] = d[15:0];
      else
         res = d;
      return res;
   endfunction

   // ==================================================
   // checks and command driver
   // ==================================================
   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("ERROR: time %0t ns %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      checks++;
      assert (cond)
      else begin
         errors++;
         $display("time %0t ns: %s", $time, msg);
      end
   endtask

   task automatic close_test(input string name);
      int total;
      total = errors + dut0.u_seq.asserts0.fail_count;
      tests_run++;
      if (total == err_mark) begin
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, total - err_mark);
      end
      err_mark = total;
   endtask

   task automatic run_cmd(input logic st, input lsu_width_t f3, input logic [31:0] a,
                          input logic [31:0] d);
      logic [`LSU_RAM_AW-1:0] idx;
      logic                   mis;
      logic [31:0]            exp_rd;
      int                     lat;
      int                     exp_lat;
      logic                   seen;
      logic                   busy_ok;
      idx     = a[`LSU_RAM_AW+1:2];
      mis     = is_misaligned(f3, a);
      exp_rd  = load_value(ref_mem[idx], f3, a[1:0]);
      exp_lat = mis ? 34 : (st ? 36 : 68);
      seen    = 1'b0;
      busy_ok = 1'b1;
      @(posedge clk);
      start  <= 1'b1;
      store  <= st;
      funct3 <= f3;
      addr   <= a;
      wdata  <= d;
      @(posedge clk);
      start <= 1'b0;
      lat = 1;
      while (!seen && (lat <= 2 * exp_lat)) begin
         @(negedge clk);
         busy_ok &= busy;
         if (done) begin
            seen = 1'b1;
         end else begin
            @(posedge clk);
            lat++;
         end
      end
      check_true(seen, "o_done never rose for a command");
      check_true(busy_ok, "o_busy dropped while a command was running");
      check_value("o_done latency", lat, exp_lat);
      check_value("o_misalign", 32'(misalign), 32'(mis));
      if (!st && !mis)
         check_value("o_rdata", rdata, exp_rd);
      if (st && !mis)
         ref_mem[idx] = store_merge(ref_mem[idx], d, f3, a[1:0]);
   endtask

   // ==================================================
   // test sequence
   // ==================================================
   initial begin
      logic [31:0] a;
      logic [31:0] off;
      logic [1:0]  kind;
      logic        st;
      for (int w = 0; w < (1 << `LSU_RAM_AW); w++)
         ref_mem[w] = '0;
      rst    = 1'b1;
      start  = 1'b0;
      store  = 1'b0;
      funct3 = LSU_W;
      addr   = '0;
      wdata  = '0;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_true(!busy && !done, "o_busy or o_done high after reset");

      for (int n = 0; n < N_WORD; n++) begin
         a = rand_bits(30) << 2;
         run_cmd(1'b1, LSU_W, a, rand_bits(32));
         run_cmd(1'b0, LSU_W, a, 32'd0);
      end
      close_test("word_store_reload");

      for (int n = 0; n < N_BYTE; n++) begin
         a = rand_bits(30) << 2;
         for (int o = 0; o < 4; o++) begin
            run_cmd(1'b1, LSU_B, a | o, rand_bits(32));
            run_cmd(1'b0, LSU_W, a, 32'd0); // only the stored byte may change.
         end
      end
      close_test("byte_stores");

      for (int n = 0; n < N_SIGN; n++) begin
         a = rand_bits(30) << 2;
         run_cmd(1'b1, LSU_W, a, rand_bits(32));
         run_cmd(1'b0, LSU_B, a | rand_bits(2), 32'd0);
         run_cmd(1'b0, LSU_BU, a | rand_bits(2), 32'd0);
         run_cmd(1'b0, LSU_H, a | (rand_bits(1) << 1), 32'd0);
         run_cmd(1'b0, LSU_HU, a | (rand_bits(1) << 1), 32'd0);
      end
      close_test("sign_extension");

      for (int n = 0; n < N_MIS; n++) begin
         a    = rand_bits(30) << 2;
         kind = 2'(n); // bit 1 picks word, bit 0 picks store.
         if (kind[1]) begin
            do
               off = rand_bits(2);
            while (off == 0);
            run_cmd(kind[0], LSU_W, a | off, rand_bits(32));
         end else begin
            run_cmd(kind[0], LSU_H, a | (rand_bits(1) << 1) | 1, rand_bits(32));
         end
         run_cmd(1'b0, LSU_W, a, 32'd0); // memory must be untouched.
      end
      close_test("misalignment");

      a = rand_bits(30) << 2;
      run_cmd(1'b1, LSU_W, a, rand_bits(32));
      run_cmd(1'b0, LSU_W, a, 32'd0);
      run_cmd(1'b1, LSU_W, a | 2, rand_bits(32));
      run_cmd(1'b0, LSU_H, a | 1, 32'd0);
      close_test("fixed_latency");

      for (int n = 0; n < N_RAND; n++) begin
         st = (rand_bits(1) == 32'd1);
         run_cmd(st, pick_width(st), rand_bits(32), rand_bits(32));
      end
      close_test("random_mix");

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               tests_run, tests_failed, checks, errors, dut0.u_seq.asserts0.fail_count);
      if ((errors == 0) && (tests_failed == 0) && (dut0.u_seq.asserts0.fail_count == 0)) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      #(WDOG_NS);
      $display("watchdog expired after %0d ns, a command did not complete", WDOG_NS);
      $display("Test FAILED");
      $finish;
   end

endmodule

//--- sim.f
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_bus_if.sv
rtl/lsu_sequencer.sv
rtl/ser_mem_if.sv
rtl/wb_ram.sv
rtl/ser_lsu_top.sv
verif/tb_clkgen.sv
verif/ser_lsu_asserts.sv
verif/tb_ser_lsu.sv

//--- run_sim.sh
#!/bin/sh
# builds the serial load/store testbench with verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timing -Wno-fatal -j 0 \
   --top-module tb_ser_lsu --Mdir "$OBJ" -f sim.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ/Vtb_ser_lsu" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
